//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - target: any(rtl, test)
    include_dirs:
      - src
    files:
      - src/mem_pkg.sv
      - src/main_memory.sv
      - src/cache_store.sv
      - src/cache_controller.sv
      - src/mem_subsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/mem_subsystem_properties.sv
      - test/tb_mem_subsystem.sv

//--- project.f
+incdir+src
src/mem_pkg.sv
src/main_memory.sv
src/cache_store.sv
src/cache_controller.sv
src/mem_subsystem.sv
test/mem_subsystem_properties.sv
test/tb_mem_subsystem.sv

//--- src/cache_controller.sv
`timescale 1ns/10ps

module cache_controller
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  cpu_req_t cpu_req,
    output logic     cpu_ready,
    output word_t    cpu_rdata,
    input  logic     hit,
    input  word_t    hit_data,
    output logic     fill,
    output logic     update,
    output mem_req_t mem_req,
    input  logic     mem_ready,
    input  word_t    mem_rdata
);

    ctrl_state_t state;
    logic        hit_pend;    // read hit, answered on the following edge.
    logic        req_valid;
    logic        take_hit;

    assign req_valid = cpu_req.read || cpu_req.write;

    // read hit found in the first lookup cycle.
    assign take_hit = (state == lookup) && !hit_pend && cpu_req.read && !cpu_req.write && hit;

    // store strobes last for the cycle in which mem_ready is high.
    assign fill   = (state == mem_read) && mem_ready;
    assign update = (state == mem_write) && mem_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            hit_pend  <= 1'b0;
            cpu_ready <= 1'b0;
            mem_req   <= '0;
        end else begin
            cpu_ready <= 1'b0;
            case (state)
                idle: begin
                    // cpu_ready still high means the old request is being dropped.
                    if (req_valid && !cpu_ready) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (hit_pend) begin
                        hit_pend  <= 1'b0;
                        cpu_ready <= 1'b1;
                        state     <= idle;
                    end else if (cpu_req.write) begin
                        // write-through, always goes to memory.
                        mem_req.read  <= 1'b0;
                        mem_req.write <= 1'b1;
                        mem_req.addr  <= cpu_req.addr;
                        mem_req.wdata <= cpu_req.wdata;
                        state         <= mem_write;
                    end else if (take_hit) begin
                        hit_pend <= 1'b1;
                    end else begin
                        // read miss.
                        mem_req.read  <= 1'b1;
                        mem_req.write <= 1'b0;
                        mem_req.addr  <= cpu_req.addr;
                        mem_req.wdata <= cpu_req.wdata;
                        state         <= mem_read;
                    end
                end
                mem_read,
                mem_write: begin
                    if (mem_ready) begin
                        mem_req.read  <= 1'b0;   // drop on the edge that sees ready.
                        mem_req.write <= 1'b0;
                        cpu_ready     <= 1'b1;
                        state         <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // response word, valid while cpu_ready is high.
    always_ff @(posedge clk) begin
        if (take_hit) begin
            cpu_rdata <= hit_data;
        end else if (fill) begin
            cpu_rdata <= mem_rdata;   // same word that goes into the line.
        end
    end

endmodule

//--- src/cache_store.sv
`timescale 1ns/10ps

`include "mem_defs.svh"

module cache_store
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t addr,
    input  logic  fill,
    input  logic  update,
    input  word_t wdata,
    output logic  hit,
    output word_t hit_data
);

    logic  [`CACHE_LINES-1:0] valid;
    tag_t  tags  [`CACHE_LINES];
    word_t words [`CACHE_LINES];

    index_t idx;
    tag_t   tag;

    // index from bits 5:2, tag from the rest of the memory address.
    assign idx = addr[`INDEX_BITS+1:2];
    assign tag = addr[`MEM_ADDR_BITS-1:`INDEX_BITS+2];

    // combinational lookup for the held address.
    assign hit      = valid[idx] && (tags[idx] == tag);
    assign hit_data = words[idx];

    // valid bits, a line becomes valid on its first fill.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill) begin
            valid[idx] <= 1'b1;
        end
    end

    // tag array only changes on a fill.
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[idx] <= tag;
        end
    end

    // data array.
    // fill replaces the line, update only touches a line that hits.
    always_ff @(posedge clk) begin
        if (fill || (update && hit)) begin
            words[idx] <= wdata;
        end
    end

endmodule

//--- src/main_memory.sv
`timescale 1ns/10ps

`include "mem_defs.svh"

module main_memory
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    output word_t    mem_rdata,
    output logic     mem_ready
);

    logic [7:0] mem [`MEM_BYTES];   // byte array, contents undefined until written.

    logic [3:0] delay_cnt;
    logic       req_active;
    logic       at_term;

    // word-aligned byte offset inside the memory, wraps on the low address bits.
    logic [`MEM_ADDR_BITS-3:0] word_sel;

    assign req_active = mem_req.read || mem_req.write;
    assign at_term    = req_active && (delay_cnt == `MEM_LATENCY);
    assign word_sel   = mem_req.addr[`MEM_ADDR_BITS-1:2];

    // latency counter, restarts whenever the request is dropped.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            delay_cnt <= '0;
            mem_ready <= 1'b0;
        end else if (req_active) begin
            if (at_term) begin
                delay_cnt <= '0;
                mem_ready <= 1'b1;   // one cycle pulse.
            end else begin
                delay_cnt <= delay_cnt + 4'd1;
                mem_ready <= 1'b0;
            end
        end else begin
            delay_cnt <= '0;
            mem_ready <= 1'b0;
        end
    end

    // byte array access at the terminal count, little-endian.
    always_ff @(posedge clk) begin
        if (at_term && mem_req.write) begin
            mem[{word_sel, 2'd0}] <= mem_req.wdata[7:0];
            mem[{word_sel, 2'd1}] <= mem_req.wdata[15:8];
            mem[{word_sel, 2'd2}] <= mem_req.wdata[23:16];
            mem[{word_sel, 2'd3}] <= mem_req.wdata[31:24];
        end
    end

    // read word is registered on the edge that raises mem_ready.
    // a write returns the word just stored, so the cache can take
    // its line data from mem_rdata for both fill and update.
    always_ff @(posedge clk) begin
        if (at_term) begin
            if (mem_req.read) begin
                mem_rdata <= {
                    mem[{word_sel, 2'd3}],
                    mem[{word_sel, 2'd2}],
                    mem[{word_sel, 2'd1}],
                    mem[{word_sel, 2'd0}]
                };
            end else begin
                mem_rdata <= mem_req.wdata;
            end
        end
    end

endmodule

//--- src/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// word and address widths of the cpu port.
`define DATA_WIDTH    32
`define ADDR_WIDTH    32

// main memory geometry.
`define MEM_BYTES     16384
`define MEM_ADDR_BITS 14     // upper address bits are ignored, so accesses wrap.

// terminal value of the memory delay counter.
`define MEM_LATENCY   10

// direct-mapped cache, one word per line.
`define CACHE_LINES   16
`define INDEX_BITS    4      // address bits 5 to 2.
`define TAG_BITS      8      // address bits 13 to 6.

`endif

//--- src/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // data and address vectors.
    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // cache line selection and tag compare.
    typedef logic [`INDEX_BITS-1:0] index_t;
    typedef logic [`TAG_BITS-1:0]   tag_t;

    // request from the processor, held until cpu_ready.
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    // request from the cache controller, held until mem_ready.
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // cache controller states.
    typedef enum logic [1:0] {
        idle,
        lookup,
        mem_read,
        mem_write
    } ctrl_state_t;

endpackage

//--- src/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  cpu_req_t cpu_req,
    output logic     cpu_ready,
    output word_t    cpu_rdata
);

    mem_req_t mem_req;
    logic     mem_ready;
    word_t    mem_rdata;

    logic     hit;
    word_t    hit_data;
    logic     fill;
    logic     update;

    cache_controller ctrl0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .hit       (hit),
        .hit_data  (hit_data),
        .fill      (fill),
        .update    (update),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    // line data always comes back through the memory read word.
    cache_store store0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (cpu_req.addr),
        .fill     (fill),
        .update   (update),
        .wdata    (mem_rdata),
        .hit      (hit),
        .hit_data (hit_data)
    );

    main_memory mem0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

endmodule

//--- test/mem_subsystem_properties.sv
`timescale 1ns/10ps

`include "mem_defs.svh"

module mem_subsystem_properties
    import mem_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input cpu_req_t cpu_req,
    input logic     cpu_ready,
    input mem_req_t mem_req,
    input logic     mem_ready
);

    localparam int WRITE_CYCLES = 13;   // edge 0 to the edge that raises cpu_ready.

    int   failures;
    logic seen_req;
    logic mem_active;

    assign mem_active = mem_req.read || mem_req.write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_req <= 1'b0;
        end else if (cpu_req.read || cpu_req.write) begin
            seen_req <= 1'b1;
        end
    end

    // no response before the first request.
    no_early_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> !cpu_ready)
        else begin failures++; $error("cpu_ready raised before any request"); end

    ready_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |=> !cpu_ready)
        else begin failures++; $error("cpu_ready high for two cycles"); end

    mem_ready_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready)
        else begin failures++; $error("mem_ready high for two cycles"); end

    one_mem_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.read && mem_req.write))
        else begin failures++; $error("mem_req has read and write set"); end

    // fixed memory latency from the first cycle the request is seen.
    mem_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_active) |-> !mem_ready [*(`MEM_LATENCY + 1)] ##1 mem_ready)
        else begin failures++; $error("memory latency is wrong"); end

    write_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_req.write) |-> !cpu_ready [*(WRITE_CYCLES + 1)] ##1 cpu_ready)
        else begin failures++; $error("write latency is wrong"); end

endmodule

//--- test/tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem
    import mem_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int HIT_CYCLES  = 2;
    localparam int MISS_CYCLES = 13;
    localparam int MAX_WAIT    = 40;    // per request, in cycles.
    localparam int N_DIRECTED  = 11;
    localparam int N_RANDOM    = 200;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 16 + 100;

    logic     clk;
    logic     rst_n;
    cpu_req_t cpu_req;
    logic     cpu_ready;
    word_t    cpu_rdata;

    logic [31:0] lfsr_state;
    int          err_count;

    // reference model, one entry per memory word.
    word_t         ref_data [4096];
    logic [4095:0] ref_written;

    // tag model of the cache lines.
    logic [15:0] line_valid;
    tag_t        line_tag [16];

    mem_subsystem dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata)
    );

    bind mem_subsystem mem_subsystem_properties props0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic index_t index_from_sel(input logic [1:0] sel);
        case (sel)
            2'd0:    return 4'd0;
            2'd1:    return 4'd3;
            2'd2:    return 4'd9;
            default: return 4'd15;
        endcase
    endfunction

    function automatic tag_t tag_from_sel(input logic [1:0] sel);
        case (sel)
            2'd0:    return 8'h00;
            2'd1:    return 8'h41;
            2'd2:    return 8'h9c;
            default: return 8'hff;
        endcase
    endfunction

    // called 2 ns after a rising edge, returns at the same phase.
    task automatic run_request(input logic is_write, input addr_t addr, input word_t wdata);
        index_t      idx;
        tag_t        tag;
        logic [11:0] widx;
        int          exp_lat;
        int          lat;
        logic        done;
        logic        timed_out;
        word_t       got;
        idx  = addr[5:2];
        tag  = addr[13:6];
        widx = addr[13:2];       // bits above 13 wrap.
        if (!is_write && line_valid[idx] && (line_tag[idx] == tag)) begin
            exp_lat = HIT_CYCLES;
        end else begin
            exp_lat = MISS_CYCLES;   // writes always go to memory.
        end
        cpu_req.read  = !is_write;
        cpu_req.write = is_write;
        cpu_req.addr  = addr;
        cpu_req.wdata = is_write ? wdata : '0;
        lat       = 0;
        done      = 1'b0;
        timed_out = 1'b0;
        got       = '0;
        while (!done) begin
            @(posedge clk);
            #1;
            if (cpu_ready) begin
                done = 1'b1;
                got  = cpu_rdata;    // only valid in the ready cycle.
            end else begin
                lat++;
                if (lat > MAX_WAIT) begin
                    timed_out = 1'b1;
                    done      = 1'b1;
                end
            end
        end
        if (timed_out) begin
            $display("request to address %h got no cpu_ready within %0d cycles", addr, MAX_WAIT);
            err_count++;
        end else begin
            assert (lat == exp_lat) else begin
                $display("CHECK FAILED at %0t: %s at %h took %0d cycles, expected %0d",
                         $time, is_write ? "write" : "read", addr, lat, exp_lat);
                err_count++;
            end
            if (!is_write && ref_written[widx]) begin
                assert (got === ref_data[widx]) else begin
                    $display("CHECK FAILED at %0t: read at %h returned %h, expected %h",
                             $time, addr, got, ref_data[widx]);
                    err_count++;
                end
            end
        end
        #1;
        cpu_req = '0;
        if (is_write) begin
            ref_data[widx]    = wdata;
            ref_written[widx] = 1'b1;
        end else begin
            line_valid[idx] = 1'b1;  // read fills the line.
            line_tag[idx]   = tag;
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        addr_t       addr_a;
        addr_t       addr_b;
        addr_t       addr;
        word_t       data;
        logic        op;
        logic [1:0]  isel;
        logic [1:0]  tsel;
        logic [1:0]  hsel;
        int          prop_fails;
        cpu_req     = '0;
        rst_n       = 1'b0;
        lfsr_state  = 32'h6398_6056;
        err_count   = 0;
        ref_written = '0;
        line_valid  = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);   // idle, no request yet.
        #2;

        // same index, two tags.
        addr_a = {18'h0, 8'h12, 4'd6, 2'b00};
        addr_b = {18'h0, 8'h34, 4'd6, 2'b00};
        run_request(1'b1, addr_a, 32'hcafe_0001);
        run_request(1'b1, addr_b, 32'hbeef_0002);
        run_request(1'b0, addr_a, '0);
        run_request(1'b0, addr_a, '0);
        run_request(1'b0, addr_b, '0);   // evicts a.
        run_request(1'b0, addr_a, '0);   // evicts b.
        run_request(1'b1, addr_a, 32'h1234_5678);
        run_request(1'b0, addr_a | 32'h0001_0000, '0);   // alias above bit 13.
        run_request(1'b1, addr_b, 32'h8765_4321);        // write miss, line kept.
        run_request(1'b0, addr_a, '0);
        run_request(1'b0, addr_b, '0);

        for (int i = 0; i < N_RANDOM; i++) begin
            op   = 1'(take_bits(1));
            isel = 2'(take_bits(2));
            tsel = 2'(take_bits(2));
            hsel = 2'(take_bits(2));
            addr = {16'h0, hsel, tag_from_sel(tsel), index_from_sel(isel), 2'b00};
            data = op ? take_bits(32) : '0;
            run_request(op, addr, data);
        end

        repeat (4) @(posedge clk);
        prop_fails = dut0.props0.failures;
        $display("errors: %0d data and latency, %0d protocol", err_count, prop_fails);
        if (err_count == 0 && prop_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule
